/* verification/acq_stimulus.txt */
# name cfg_sample cfg_num_dev expected_len_pkg expected_tbit_period
# decimal values, one test per row, load_per_sample is 9
rate20_low 20 3 242 50
rate10_mid 10 8 152 50
rate5_high 5 20 107 50
rate2_low 2 3 80 500
rate1_mid 1 8 71 500
rate1_high 1 20 71 200
bad7_high 7 20 242 20

/* vlog.f */
+incdir+verification
logic/acq_pkg.sv
logic/fetch_base.sv
logic/tbit_gen.sv
logic/pkt_assembler.sv
logic/pkt_drainer.sv
logic/pkt_buffer_arb.sv
logic/acq_top.sv
verification/tb_acq_top.sv

/* Makefile */
# Verilator build and run for the acquisition front end testbench

VERILATOR ?= verilator
TOP ?= tb_acq_top
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* verification/tb_checks.svh */
// typed compare tasks and crc-16 reference model for the acquisition testbench
`ifndef tb_checks_svh
`define tb_checks_svh

	// ------------------------------------------------------------------------
	// compare tasks, one per kind of result
	// ------------------------------------------------------------------------
	task automatic check_len(input string tname, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			$display("error %s length expected %0d actual %0d", tname, expected, actual);
			$display("sim failed");
			$fatal(1, "length mismatch");
		end
	endtask

	task automatic check_period(input string tname, input logic [19:0] expected,
		input logic [19:0] actual);
		if (actual !== expected) begin
			$display("error %s period expected %0d actual %0d", tname, expected, actual);
			$display("sim failed");
			$fatal(1, "period mismatch");
		end
	endtask

	task automatic check_word(input string tname, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			$display("error %s word expected %h actual %h", tname, expected, actual);
			$display("sim failed");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_flag(input string tname, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("error %s flag expected %b actual %b", tname, expected, actual);
			$display("sim failed");
			$fatal(1, "marker mismatch");
		end
	endtask

	// ccitt polynomial, whole word folded into the register before shifting
	function automatic logic [15:0] crc_update(input logic [15:0] crc_in, input logic [15:0] word);
		logic [15:0] r;
		r = crc_in ^ word;
		repeat (16) begin
			r = r[15] ? ((r << 1) ^ acq_pkg::crc_poly) : (r << 1);
		end
		return r;
	endfunction

`endif

/* verification/tb_acq_top.sv */
// testbench for the acquisition front end, file driven frames with full content checks
`timescale 1ns/1ps

module tb_acq_top;

	localparam int load_per_sample = 9;
	localparam int frame_overhead = int'(acq_pkg::len_head + acq_pkg::len_tail + acq_pkg::len_crc);
	localparam int head_words = int'(acq_pkg::len_head);

	logic        clk_sys;
	logic        arst_n;
	logic        run;
	logic [7:0]  cfg_sample;
	logic [7:0]  cfg_num_dev;
	logic [15:0] sample_data;
	logic [15:0] out_word;
	logic        out_valid;
	logic        out_sop;
	logic        out_eop;
	logic [15:0] len_pkg;
	logic [19:0] tbit_period;

	// one entry per stimulus row
	string name_q[$];
	int    rate_q[$];
	int    ndev_q[$];
	int    len_q[$];
	int    period_q[$];

	int seed = 32'h8aae31c4;
	int cycle_cnt = 0;
	int cycle_limit = 0;

	`include "tb_checks.svh"

	acq_top #(
		.load_per_sample(load_per_sample)
	) UUT (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.run         (run),
		.cfg_sample  (cfg_sample),
		.cfg_num_dev (cfg_num_dev),
		.sample_data (sample_data),
		.out_word    (out_word),
		.out_valid   (out_valid),
		.out_sop     (out_sop),
		.out_eop     (out_eop),
		.len_pkg     (len_pkg),
		.tbit_period (tbit_period)
	);

	always #50 clk_sys = ~clk_sys;

	// limit is zero until the stimulus rows are known
	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("run exceeded %0d cycles before all frames were drained", cycle_limit);
			$display("sim failed");
			$fatal(1, "timeout");
		end
	end

	// density mode from the device count
	function automatic acq_pkg::mode_t expected_mode(input int ndev);
		if (ndev >= 16) begin
			return acq_pkg::mode_high;
		end else if (ndev >= 8) begin
			return acq_pkg::mode_mid;
		end
		return acq_pkg::mode_low;
	endfunction

	// bit frequency implied by a bit period
	function automatic logic [15:0] frq_for_period(input int period);
		case (period)
			25:      return 16'd4000;
			50:      return 16'd2000;
			100:     return 16'd1000;
			200:     return 16'd500;
			500:     return 16'd200;
			default: return 16'd5000;
		endcase
	endfunction

	task automatic load_stimulus();
		int    fd;
		int    rc;
		int    smp;
		int    nd;
		int    el;
		int    ep;
		string line;
		string nm;
		fd = $fopen("verification/acq_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file verification/acq_stimulus.txt");
			$display("sim failed");
			$fatal(1, "no stimulus");
		end
		while (!$feof(fd)) begin
			rc = $fgets(line, fd);
			// skip comments and blank lines
			if (rc > 0 && line.getc(0) != "#") begin
				rc = $sscanf(line, "%s %d %d %d %d", nm, smp, nd, el, ep);
				if (rc == 5) begin
					name_q.push_back(nm);
					rate_q.push_back(smp);
					ndev_q.push_back(nd);
					len_q.push_back(el);
					period_q.push_back(ep);
				end
			end
		end
		$fclose(fd);
	endtask

	// ------------------------------------------------------------------------
	// one test: configure, check decode, run one frame and check every word
	// ------------------------------------------------------------------------
	task automatic run_frame(input int t);
		logic [15:0] words[$];
		logic [15:0] sample_val;
		logic [15:0] crc;
		logic [15:0] dev_word;
		int          n;
		int          exp_len;
		int          payload;
		bit          done;
		string       tname;
		tname = name_q[t];
		exp_len = len_q[t];
		payload = exp_len - frame_overhead;
		sample_val = 16'($random(seed));
		dev_word = {8'(ndev_q[t]), 6'd0, expected_mode(ndev_q[t])};

		@(posedge clk_sys);
		cfg_sample <= 8'(rate_q[t]);
		cfg_num_dev <= 8'(ndev_q[t]);
		sample_data <= sample_val;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		check_len(tname, 16'(exp_len), len_pkg);
		check_period(tname, 20'(period_q[t]), tbit_period);

		@(posedge clk_sys);
		run <= 1'b1;
		n = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk_sys);
			if (out_valid) begin
				check_flag({tname, " sop"}, n == 0, out_sop);
				check_flag({tname, " eop"}, n == exp_len - 1, out_eop);
				words.push_back(out_word);
				n++;
				done = out_eop;
			end
			// frame has started, no second frame wanted
			if (out_sop && run) begin
				@(posedge clk_sys);
				run <= 1'b0;
			end
		end

		check_word({tname, " sync"}, acq_pkg::sync_word, words[0]);
		check_word({tname, " length"}, 16'(exp_len), words[1]);
		check_word({tname, " devices"}, dev_word, words[2]);
		check_word({tname, " frequency"}, frq_for_period(period_q[t]), words[3]);
		check_word({tname, " sequence"}, 16'(t), words[4]);
		for (int k = 5; k < head_words; k++) begin
			check_word($sformatf("%s header %0d", tname, k), 16'h0000, words[k]);
		end
		for (int k = head_words; k < head_words + payload; k++) begin
			check_word($sformatf("%s payload %0d", tname, k), sample_val, words[k]);
		end
		for (int k = head_words + payload; k < exp_len - 2; k++) begin
			check_word($sformatf("%s tail %0d", tname, k), 16'h0000, words[k]);
		end

		crc = acq_pkg::crc_init;
		for (int k = 0; k < exp_len - 2; k++) begin
			crc = crc_update(crc, words[k]);
		end
		check_word({tname, " crc"}, crc, words[exp_len - 2]);
		check_word({tname, " crc complement"}, ~crc, words[exp_len - 1]);
	endtask

	initial begin
		clk_sys = 1'b0;
		arst_n = 1'b0;
		run = 1'b0;
		cfg_sample = 8'd20;
		cfg_num_dev = 8'd0;
		sample_data = 16'h0000;

		load_stimulus();
		if (name_q.size() == 0) begin
			$display("the stimulus file holds no test rows");
			$display("sim failed");
			$fatal(1, "empty stimulus");
		end
		for (int i = 0; i < name_q.size(); i++) begin
			cycle_limit += (len_q[i] - frame_overhead) * period_q[i] + 400;
		end

		repeat (5) @(posedge clk_sys);
		arst_n <= 1'b1;

		for (int t = 0; t < name_q.size(); t++) begin
			run_frame(t);
		end

		$display("sim passed");
		$finish;
	end

endmodule

/* logic/acq_top.sv */
// acquisition front end top, config decode through timing, framing, buffer and output
`timescale 1ns/1ps

module acq_top #(
	parameter int load_per_sample = 900
) (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        run,
	input  logic [7:0]  cfg_sample,
	input  logic [7:0]  cfg_num_dev,
	input  logic [15:0] sample_data,
	output logic [15:0] out_word,
	output logic        out_valid,
	output logic        out_sop,
	output logic        out_eop,
	output logic [15:0] len_pkg,
	output logic [19:0] tbit_period
);

	acq_pkg::mode_t                     mode;
	logic [15:0]                        tbit_frq;
	logic                               tbit_stb;
	logic                               wr_req;
	logic                               wr_gnt;
	logic [acq_pkg::buf_depth_log2-1:0] wr_addr;
	logic [15:0]                        wr_data;
	logic [15:0]                        wr_count;
	logic                               rd_req;
	logic                               rd_gnt;
	logic [acq_pkg::buf_depth_log2-1:0] rd_addr;
	logic [15:0]                        rd_data;

	fetch_base #(
		.load_per_sample(load_per_sample)
	) u_fetch_base (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.cfg_sample  (cfg_sample),
		.cfg_num_dev (cfg_num_dev),
		.len_pkg     (len_pkg),
		.mode        (mode),
		.tbit_frq    (tbit_frq),
		.tbit_period (tbit_period)
	);

	tbit_gen u_tbit_gen (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.tbit_period (tbit_period),
		.tbit_stb    (tbit_stb)
	);

	pkt_assembler u_pkt_assembler (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.run         (run),
		.len_pkg     (len_pkg),
		.mode        (mode),
		.tbit_frq    (tbit_frq),
		.cfg_num_dev (cfg_num_dev),
		.tbit_stb    (tbit_stb),
		.sample_data (sample_data),
		.wr_gnt      (wr_gnt),
		.wr_req      (wr_req),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.wr_count    (wr_count)
	);

	pkt_buffer_arb u_pkt_buffer_arb (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.wr_req  (wr_req),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_req  (rd_req),
		.rd_addr (rd_addr),
		.wr_gnt  (wr_gnt),
		.rd_gnt  (rd_gnt),
		.rd_data (rd_data)
	);

	pkt_drainer u_pkt_drainer (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.wr_count  (wr_count),
		.rd_gnt    (rd_gnt),
		.rd_data   (rd_data),
		.rd_req    (rd_req),
		.rd_addr   (rd_addr),
		.out_word  (out_word),
		.out_valid (out_valid),
		.out_sop   (out_sop),
		.out_eop   (out_eop)
	);

endmodule

/* logic/pkt_buffer_arb.sv */
// single-port packet memory shared by writer and reader with alternating priority
`timescale 1ns/1ps

module pkt_buffer_arb (
	input  logic                                 clk_sys,
	input  logic                                 arst_n,
	input  logic                                 wr_req,
	input  logic [acq_pkg::buf_depth_log2-1:0]   wr_addr,
	input  logic [15:0]                          wr_data,
	input  logic                                 rd_req,
	input  logic [acq_pkg::buf_depth_log2-1:0]   rd_addr,
	output logic                                 wr_gnt,
	output logic                                 rd_gnt,
	output logic [15:0]                          rd_data
);

	localparam int depth = 1 << acq_pkg::buf_depth_log2;

	logic [15:0]                        mem [0:depth-1];
	logic [acq_pkg::buf_depth_log2-1:0] addr;
	logic                               last_rd;

	// ------------------------------------------------------------------------
	// arbitration, the side served last loses a tie
	// ------------------------------------------------------------------------
	assign wr_gnt = wr_req && (!rd_req || last_rd);
	assign rd_gnt = rd_req && (!wr_req || !last_rd);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			last_rd <= 1'b0;
		end else if (rd_gnt) begin
			last_rd <= 1'b1;
		end else if (wr_gnt) begin
			last_rd <= 1'b0;
		end
	end

	// ------------------------------------------------------------------------
	// one access per cycle through a single address
	// ------------------------------------------------------------------------
	assign addr = wr_gnt ? wr_addr : rd_addr;

	always_ff @(posedge clk_sys) begin
		if (wr_gnt) begin
			mem[addr] <= wr_data;
		end else if (rd_gnt) begin
			rd_data <= mem[addr];
		end
	end

	// a refused requester keeps its address and wins the next cycle
	a_wr_wait: assert property (@(posedge clk_sys) disable iff (!arst_n)
		wr_req && !wr_gnt |=> wr_gnt && $stable(wr_addr));

	a_rd_wait: assert property (@(posedge clk_sys) disable iff (!arst_n)
		rd_req && !rd_gnt |=> rd_gnt && $stable(rd_addr));

endmodule

/* logic/pkt_drainer.sv */
// frame reader streaming buffered words out with start and end of frame markers
`timescale 1ns/1ps

module pkt_drainer (
	input  logic                                 clk_sys,
	input  logic                                 arst_n,
	input  logic [15:0]                          wr_count,
	input  logic                                 rd_gnt,
	input  logic [15:0]                          rd_data,
	output logic                                 rd_req,
	output logic [acq_pkg::buf_depth_log2-1:0]   rd_addr,
	output logic [15:0]                          out_word,
	output logic                                 out_valid,
	output logic                                 out_sop,
	output logic                                 out_eop
);

	acq_pkg::drain_state_t state;
	logic [15:0]           rd_cnt;
	logic [15:0]           pos;
	logic [15:0]           frame_len;
	logic                  more;
	logic                  last;

	// words written but not yet read, counters wrap together
	assign more = (rd_cnt != wr_count);
	assign rd_req = (state == acq_pkg::dr_fetch);
	assign rd_addr = rd_cnt[acq_pkg::buf_depth_log2-1:0];

	assign out_valid = (state == acq_pkg::dr_emit);
	assign out_word = rd_data;
	assign last = (pos > 16'd1) && (pos == frame_len - 16'd1);
	assign out_sop = out_valid && (pos == 16'd0);
	assign out_eop = out_valid && last;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state <= acq_pkg::dr_idle;
			rd_cnt <= 16'd0;
			pos <= 16'd0;
			frame_len <= 16'd0;
		end else begin
			case (state)
				acq_pkg::dr_idle: begin
					if (more) begin
						state <= acq_pkg::dr_fetch;
					end
				end
				acq_pkg::dr_fetch: begin
					if (rd_gnt) begin
						rd_cnt <= rd_cnt + 16'd1;
						state <= acq_pkg::dr_emit;
					end
				end
				acq_pkg::dr_emit: begin
					// header word 1 carries the frame length
					if (pos == 16'd1) begin
						frame_len <= rd_data;
					end
					pos <= last ? 16'd0 : pos + 16'd1;
					state <= more ? acq_pkg::dr_fetch : acq_pkg::dr_idle;
				end
				default: state <= acq_pkg::dr_idle;
			endcase
		end
	end

endmodule

/* logic/pkt_assembler.sv */
// frame builder writing header, sampled payload, tail and crc into the packet memory
`timescale 1ns/1ps

module pkt_assembler (
	input  logic                                 clk_sys,
	input  logic                                 arst_n,
	input  logic                                 run,
	input  logic [15:0]                          len_pkg,
	input  acq_pkg::mode_t                       mode,
	input  logic [15:0]                          tbit_frq,
	input  logic [7:0]                           cfg_num_dev,
	input  logic                                 tbit_stb,
	input  logic [15:0]                          sample_data,
	input  logic                                 wr_gnt,
	output logic                                 wr_req,
	output logic [acq_pkg::buf_depth_log2-1:0]   wr_addr,
	output logic [15:0]                          wr_data,
	output logic [15:0]                          wr_count
);

	acq_pkg::asm_state_t state;
	acq_pkg::mode_t      mode_q;
	logic [15:0]         len_q;
	logic [15:0]         frq_q;
	logic [7:0]          ndev_q;
	logic [15:0]         seq_num;
	logic [15:0]         idx;
	logic [15:0]         crc;
	logic [15:0]         sample_q;
	logic                pend;
	logic [15:0]         load_end;
	logic [15:0]         tail_end;
	logic [15:0]         head_word;

	function automatic logic [15:0] crc16_step(input logic [15:0] crc_in, input logic [15:0] data);
		logic [15:0] c;
		logic        fb;
		c = crc_in;
		for (int i = 15; i >= 0; i--) begin
			fb = c[15] ^ data[i];
			c = {c[14:0], 1'b0};
			if (fb) begin
				c = c ^ acq_pkg::crc_poly;
			end
		end
		return c;
	endfunction

	// last frame index of payload and of tail
	assign load_end = len_q - acq_pkg::len_tail - acq_pkg::len_crc - 16'd1;
	assign tail_end = len_q - acq_pkg::len_crc - 16'd1;
	assign wr_addr = wr_count[acq_pkg::buf_depth_log2-1:0];

	always_comb begin
		case (idx)
			16'd0:   head_word = acq_pkg::sync_word;
			16'd1:   head_word = len_q;
			16'd2:   head_word = {ndev_q, 6'd0, mode_q};
			16'd3:   head_word = frq_q;
			16'd4:   head_word = seq_num;
			default: head_word = 16'h0000;
		endcase
	end

	always_comb begin
		wr_req = 1'b0;
		wr_data = 16'h0000;
		case (state)
			acq_pkg::asm_head: begin
				wr_req = 1'b1;
				wr_data = head_word;
			end
			acq_pkg::asm_load: begin
				wr_req = pend;
				wr_data = sample_q;
			end
			acq_pkg::asm_tail: wr_req = 1'b1;
			acq_pkg::asm_crc_hi: begin
				wr_req = 1'b1;
				wr_data = crc;
			end
			acq_pkg::asm_crc_lo: begin
				wr_req = 1'b1;
				wr_data = ~crc;
			end
			default: ;
		endcase
	end

	// sample captured on the strobe, held until its write is granted
	always_ff @(posedge clk_sys) begin
		if (state == acq_pkg::asm_load && tbit_stb) begin
			sample_q <= sample_data;
		end
	end

	// ------------------------------------------------------------------------
	// frame FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state <= acq_pkg::asm_idle;
			mode_q <= acq_pkg::mode_low;
			len_q <= 16'd0;
			frq_q <= 16'd0;
			ndev_q <= 8'd0;
			seq_num <= 16'd0;
			idx <= 16'd0;
			crc <= acq_pkg::crc_init;
			pend <= 1'b0;
			wr_count <= 16'd0;
		end else begin
			if (state == acq_pkg::asm_load && tbit_stb) begin
				pend <= 1'b1;
			end else if (state == acq_pkg::asm_load && wr_gnt) begin
				pend <= 1'b0;
			end

			if (wr_gnt) begin
				wr_count <= wr_count + 16'd1;
				idx <= idx + 16'd1;
				if (state inside {acq_pkg::asm_head, acq_pkg::asm_load, acq_pkg::asm_tail}) begin
					crc <= crc16_step(crc, wr_data);
				end
			end

			case (state)
				acq_pkg::asm_idle: begin
					if (run) begin
						len_q <= len_pkg;
						mode_q <= mode;
						frq_q <= tbit_frq;
						ndev_q <= cfg_num_dev;
						idx <= 16'd0;
						crc <= acq_pkg::crc_init;
						pend <= 1'b0;
						state <= acq_pkg::asm_head;
					end
				end
				acq_pkg::asm_head: begin
					if (wr_gnt && idx == acq_pkg::len_head - 16'd1) begin
						state <= acq_pkg::asm_load;
					end
				end
				acq_pkg::asm_load: begin
					if (wr_gnt && idx == load_end) begin
						state <= acq_pkg::asm_tail;
					end
				end
				acq_pkg::asm_tail: begin
					if (wr_gnt && idx == tail_end) begin
						state <= acq_pkg::asm_crc_hi;
					end
				end
				acq_pkg::asm_crc_hi: begin
					if (wr_gnt) begin
						state <= acq_pkg::asm_crc_lo;
					end
				end
				acq_pkg::asm_crc_lo: begin
					if (wr_gnt) begin
						seq_num <= seq_num + 16'd1;
						state <= acq_pkg::asm_idle;
					end
				end
				default: state <= acq_pkg::asm_idle;
			endcase
		end
	end

endmodule

/* logic/tbit_gen.sv */
// bit timing generator, one sampling strobe per configured period
`timescale 1ns/1ps

module tbit_gen (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic [19:0] tbit_period,
	output logic        tbit_stb
);

	logic [19:0] period_q;
	logic [19:0] cnt;
	logic        restart;

	// new period seen, count from the top again
	assign restart = (tbit_period != period_q);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			period_q <= 20'd0;
			cnt <= '1;
			tbit_stb <= 1'b0;
		end else begin
			period_q <= tbit_period;
			if (restart) begin
				cnt <= tbit_period - 20'd1;
				tbit_stb <= 1'b0;
			end else if (cnt == 20'd0) begin
				cnt <= tbit_period - 20'd1;
				tbit_stb <= 1'b1;
			end else begin
				cnt <= cnt - 20'd1;
				tbit_stb <= 1'b0;
			end
		end
	end

	// periods are at least 20 clocks
	a_stb_single: assert property (@(posedge clk_sys) disable iff (!arst_n)
		tbit_stb |=> !tbit_stb);

endmodule

/* logic/fetch_base.sv */
// configuration decoder producing packet length, density mode and bit timing
`timescale 1ns/1ps

module fetch_base #(
	parameter int load_per_sample = 900
) (
	input  logic                 clk_sys,
	input  logic                 arst_n,
	input  logic [7:0]           cfg_sample,
	input  logic [7:0]           cfg_num_dev,
	output logic [15:0]          len_pkg,
	output acq_pkg::mode_t       mode,
	output logic [15:0]          tbit_frq,
	output logic [19:0]          tbit_period
);

	localparam logic [15:0] len_fixed = acq_pkg::len_head + acq_pkg::len_tail + acq_pkg::len_crc;
	localparam logic [15:0] len_rst = len_fixed + 16'(20 * load_per_sample);

	logic [7:0] rate_code;

	// bit frequency per density mode and rate code
	function automatic logic [15:0] frq_lookup(input acq_pkg::mode_t m, input logic [7:0] code);
		logic [15:0] f;
		case (m)
			acq_pkg::mode_high: begin
				case (code)
					8'd10:   f = 16'd4000;
					8'd5:    f = 16'd2000;
					8'd2:    f = 16'd1000;
					8'd1:    f = 16'd500;
					default: f = 16'd5000;
				endcase
			end
			acq_pkg::mode_mid: begin
				case (code)
					8'd10:   f = 16'd2000;
					8'd5:    f = 16'd1000;
					8'd2:    f = 16'd500;
					8'd1:    f = 16'd200;
					default: f = 16'd4000;
				endcase
			end
			default: begin
				case (code)
					8'd10:   f = 16'd1000;
					8'd5:    f = 16'd500;
					8'd2:    f = 16'd200;
					8'd1:    f = 16'd200;
					default: f = 16'd2000;
				endcase
			end
		endcase
		return f;
	endfunction

	// unknown rate codes behave like 20
	always_comb begin
		case (cfg_sample)
			8'd20, 8'd10, 8'd5, 8'd2, 8'd1: rate_code = cfg_sample;
			default:                        rate_code = 8'd20;
		endcase
	end

	// ------------------------------------------------------------------------
	// registered decode, frequency follows mode by one cycle
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			len_pkg <= len_rst;
			mode <= acq_pkg::mode_low;
			tbit_frq <= 16'd2000;
		end else begin
			len_pkg <= len_fixed + 16'(int'(rate_code) * load_per_sample);
			if (cfg_num_dev >= 8'd16) begin
				mode <= acq_pkg::mode_high;
			end else if (cfg_num_dev >= 8'd8) begin
				mode <= acq_pkg::mode_mid;
			end else begin
				mode <= acq_pkg::mode_low;
			end
			tbit_frq <= frq_lookup(mode, rate_code);
		end
	end

	// period in system clocks per sample bit
	always_comb begin
		case (tbit_frq)
			16'd4000: tbit_period = 20'd25;
			16'd2000: tbit_period = 20'd50;
			16'd1000: tbit_period = 20'd100;
			16'd500:  tbit_period = 20'd200;
			16'd200:  tbit_period = 20'd500;
			default:  tbit_period = 20'd20;
		endcase
	end

endmodule

/* logic/acq_pkg.sv */
// acquisition subsystem shared constants, density modes and state encodings
package acq_pkg;

	// ------------------------------------------------------------------------
	// frame layout
	// ------------------------------------------------------------------------
	localparam logic [15:0] len_head = 16'd12;
	localparam logic [15:0] len_tail = 16'd48;
	localparam logic [15:0] len_crc = 16'd2;

	// first header word of every frame
	localparam logic [15:0] sync_word = 16'heb90;

	// crc-16 ccitt, msb first
	localparam logic [15:0] crc_poly = 16'h1021;
	localparam logic [15:0] crc_init = 16'hffff;

	// packet memory holds 2**buf_depth_log2 words
	localparam int buf_depth_log2 = 8;

	// ------------------------------------------------------------------------
	// encodings
	// ------------------------------------------------------------------------
	// device density, value 2 is never produced
	typedef enum logic [1:0] {
		mode_low  = 2'd0,
		mode_mid  = 2'd1,
		mode_high = 2'd3
	} mode_t;

	typedef enum logic [2:0] {
		asm_idle,
		asm_head,
		asm_load,
		asm_tail,
		asm_crc_hi,
		asm_crc_lo
	} asm_state_t;

	typedef enum logic [1:0] {
		dr_idle,
		dr_fetch,
		dr_emit
	} drain_state_t;

endpackage
